/* src/spriteLine_defines.svh */
/* Sprite line path widths and depths
   Shared by the package, the RTL and the testbench */

`ifndef SPRITELINE_DEFINES_SVH
`define SPRITELINE_DEFINES_SVH

// Bits per pixel colour
`define PIX_W 4

// Palette bits per sprite
`define PAL_W 8

// Line buffer entry, palette above colour
`define ENTRY_W (`PAL_W + `PIX_W)

// Horizontal position, also the buffer address
`define LB_ADDR_W 9

// Entries per bank
`define LB_DEPTH 512

// Pixels in one tile row
`define TILE_PIX 8

// Bitplanes per tile row
`define PLANES 4

`endif

/* src/spritePkg.sv */
/* Sprite line path types
   One entry word seen raw or split into palette and colour */

`include "spriteLine_defines.svh"

package spritePkg;

	// Palette and colour fields of one entry
	typedef struct packed {
		logic [`PAL_W-1:0] pal;		// Sprite palette
		logic [`PIX_W-1:0] color;	// Zero is transparent
	} lbFields_t;

	// Line buffer entry
	// The raw view is stored and driven out as the colour code,
	// the field view is used to build and test pixels
	typedef union packed {
		logic [`ENTRY_W-1:0] raw;
		lbFields_t f;
	} lbEntry_u;

endpackage

/* src/tileShifter.sv */
/* Tile shifter
   Turns one 4-plane tile row into eight pixel writes, leftmost first,
   and skips transparent pixels */

`timescale 1ns/100ps
`include "spriteLine_defines.svh"

module tileShifter (
	input logic clk_12M,
	input logic nRES,
	input logic lineEnd,
	input logic tileLoad,
	input logic [`PLANES*`TILE_PIX-1:0] tileData,
	input logic [`LB_ADDR_W-1:0] tileX,
	input logic [`PAL_W-1:0] tilePal,
	input logic wbAck,
	output logic tileReady,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [`LB_ADDR_W-1:0] wbAdr,
	output spritePkg::lbEntry_u wbDat
);

	import spritePkg::*;

	localparam int STEP_W = $clog2(`TILE_PIX);

	logic busy;
	logic [STEP_W-1:0] step;
	logic [`PLANES-1:0][`TILE_PIX-1:0] planeSr;
	logic [`LB_ADDR_W-1:0] xReg;
	logic [`PAL_W-1:0] palReg;
	logic [`PIX_W-1:0] pixColor;
	logic accept;
	logic advance;

	assign accept = tileLoad && tileReady;
	assign advance = busy && (!wbStb || wbAck);	// Skipped pixels still take a cycle

	// One bit per plane, plane 3 on top
	always_comb begin
		for (int p = 0; p < `PLANES; p++) begin
			pixColor[p] = planeSr[p][`TILE_PIX-1];
		end
	end

	always_ff @(posedge clk_12M or negedge nRES) begin
		if (!nRES) begin
			busy <= 1'b0;
			step <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			step <= '0;
		end else if (advance) begin
			step <= step + 1'b1;
			if (step == STEP_W'(`TILE_PIX - 1))
				busy <= 1'b0;	// Ready again on the following cycle
		end
	end

	// Row payload, planes shift left so the MSB leads
	always_ff @(posedge clk_12M) begin
		if (accept) begin
			planeSr <= tileData;
			xReg <= tileX;
			palReg <= tilePal;
		end else if (advance) begin
			for (int p = 0; p < `PLANES; p++) begin
				planeSr[p] <= {planeSr[p][`TILE_PIX-2:0], 1'b0};
			end
		end
	end

	assign tileReady = !busy;
	assign wbCyc = busy;
	assign wbStb = busy && (pixColor != '0);
	assign wbWe = busy;	// Write-only master
	assign wbAdr = xReg + {{(`LB_ADDR_W-STEP_W){1'b0}}, step};	// Wraps past 511

	always_comb begin
		wbDat.f.pal = palReg;
		wbDat.f.color = pixColor;
	end

	// The buffer must take every write in the cycle it is strobed
	assert property (@(posedge clk_12M) disable iff (!nRES)
		wbStb |-> (wbCyc && wbAck))
		else $error("tileShifter: strobe without cycle or ack");

	// A row must complete within one line
	assert property (@(posedge clk_12M) disable iff (!nRES)
		busy |-> !lineEnd)
		else $error("tileShifter: lineEnd while a tile row is in flight");

endmodule

/* src/lineBufferPair.sv */
/* Two-bank sprite line buffer
   Wishbone writes fill the draw bank, the display bank is swept out
   and each entry reads as zero after it has been read */

`timescale 1ns/100ps
`include "spriteLine_defines.svh"

module lineBufferPair (
	input logic clk_12M,
	input logic nRES,
	input logic lineEnd,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [`LB_ADDR_W-1:0] wbAdr,
	input spritePkg::lbEntry_u wbDat,
	input logic rdEn,
	input logic [`LB_ADDR_W-1:0] rdAdr,
	output logic wbAck,
	output spritePkg::lbEntry_u rdData
);

	import spritePkg::*;

	logic drawSel;		// Bank being drawn, the other one is displayed
	logic rdSelQ;		// Bank the last read came from
	logic [1:0] wrEn;
	logic [1:0] clrEn;
	lbEntry_u bankQ [2];

	// No wait states
	assign wbAck = wbCyc && wbStb;

	assign wrEn = {drawSel, !drawSel} & {2{wbCyc && wbStb && wbWe}};
	assign clrEn = {!drawSel, drawSel} & {2{rdEn}};

	always_ff @(posedge clk_12M or negedge nRES) begin
		if (!nRES) begin
			drawSel <= 1'b0;
			rdSelQ <= 1'b0;
		end else begin
			if (lineEnd)
				drawSel <= !drawSel;
			if (rdEn)
				rdSelQ <= !drawSel;
		end
	end

	for (genvar b = 0; b < 2; b++) begin : gBank
		lbEntry_u mem [`LB_DEPTH];
		logic [`LB_DEPTH-1:0] vld;	// Entry holds a drawn pixel

		always_ff @(posedge clk_12M) begin
			if (wrEn[b])
				mem[wbAdr] <= wbDat;
		end

		// Clearing the valid bit empties the entry, reset empties the bank
		always_ff @(posedge clk_12M or negedge nRES) begin
			if (!nRES) begin
				vld <= '0;
			end else begin
				if (wrEn[b])
					vld[wbAdr] <= 1'b1;
				if (clrEn[b])
					vld[rdAdr] <= 1'b0;
			end
		end

		// Old contents read out on the clearing edge
		always_ff @(posedge clk_12M) begin
			if (clrEn[b])
				bankQ[b] <= vld[rdAdr] ? mem[rdAdr] : '0;
		end
	end

	assign rdData = bankQ[rdSelQ];

endmodule

/* src/pixelOutput.sv */
/* Sprite pixel output
   Sweeps the display bank once per line and registers the colour code
   with its transparent and not-colour-15 flags */

`timescale 1ns/100ps
`include "spriteLine_defines.svh"

module pixelOutput (
	input logic clk_12M,
	input logic nRES,
	input logic lineEnd,
	input spritePkg::lbEntry_u rdData,
	output logic [`LB_ADDR_W-1:0] rdAdr,
	output logic rdEn,
	output logic [`ENTRY_W-1:0] ob,
	output logic [`LB_ADDR_W-1:0] obX,
	output logic obValid,
	output logic pcof,
	output logic ncoo
);

	import spritePkg::*;

	logic sweeping;
	logic [`LB_ADDR_W-1:0] posQ;	// Address of the read in flight
	logic vldQ;
	lbEntry_u obQ;

	// Sweep counter, restarts on every line end
	always_ff @(posedge clk_12M or negedge nRES) begin
		if (!nRES) begin
			sweeping <= 1'b0;
			rdAdr <= '0;
		end else if (lineEnd) begin
			sweeping <= 1'b1;
			rdAdr <= '0;
		end else if (sweeping) begin
			rdAdr <= rdAdr + 1'b1;
			if (rdAdr == `LB_ADDR_W'(`LB_DEPTH - 1))
				sweeping <= 1'b0;
		end
	end

	assign rdEn = sweeping;

	// Position and valid follow the read through the buffer
	always_ff @(posedge clk_12M or negedge nRES) begin
		if (!nRES) begin
			vldQ <= 1'b0;
			obValid <= 1'b0;
		end else begin
			vldQ <= rdEn;
			obValid <= vldQ;
		end
	end

	always_ff @(posedge clk_12M) begin
		posQ <= rdAdr;
		obX <= posQ;
		obQ <= rdData;
	end

	assign ob = obQ.raw;
	assign pcof = (obQ.f.color == '0);	// Transparent
	assign ncoo = !(obQ.f.color == '1);	// Low for colour 15

	// Within a sweep the address only climbs
	assert property (@(posedge clk_12M) disable iff (!nRES)
		(rdEn && !lineEnd) |=> (!rdEn || (rdAdr > $past(rdAdr))))
		else $error("pixelOutput: read address wrapped during a sweep");

endmodule

/* src/spriteLineTop.sv */
/* Sprite line path top
   Tile shifter feeds the two-bank line buffer, pixel output sweeps it */

`timescale 1ns/100ps
`include "spriteLine_defines.svh"

module spriteLineTop (
	input logic clk_12M,
	input logic nRES,
	input logic lineEnd,
	input logic tileLoad,
	input logic [`PLANES*`TILE_PIX-1:0] tileData,
	input logic [`LB_ADDR_W-1:0] tileX,
	input logic [`PAL_W-1:0] tilePal,
	output logic tileReady,
	output logic [`ENTRY_W-1:0] ob,
	output logic [`LB_ADDR_W-1:0] obX,
	output logic obValid,
	output logic pcof,
	output logic ncoo
);

	import spritePkg::*;

	// Pixel write bus
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic wbAck;
	logic [`LB_ADDR_W-1:0] wbAdr;
	lbEntry_u wbDat;

	// Display sweep
	logic rdEn;
	logic [`LB_ADDR_W-1:0] rdAdr;
	lbEntry_u rdData;

	tileShifter tileShifter_inst (
		.clk_12M(clk_12M),
		.nRES(nRES),
		.lineEnd(lineEnd),
		.tileLoad(tileLoad),
		.tileData(tileData),
		.tileX(tileX),
		.tilePal(tilePal),
		.wbAck(wbAck),
		.tileReady(tileReady),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDat(wbDat)
	);

	lineBufferPair lineBufferPair_inst (
		.clk_12M(clk_12M),
		.nRES(nRES),
		.lineEnd(lineEnd),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDat(wbDat),
		.rdEn(rdEn),
		.rdAdr(rdAdr),
		.wbAck(wbAck),
		.rdData(rdData)
	);

	pixelOutput pixelOutput_inst (
		.clk_12M(clk_12M),
		.nRES(nRES),
		.lineEnd(lineEnd),
		.rdData(rdData),
		.rdAdr(rdAdr),
		.rdEn(rdEn),
		.ob(ob),
		.obX(obX),
		.obValid(obValid),
		.pcof(pcof),
		.ncoo(ncoo)
	);

endmodule

/* verif/spriteLineChecker.sv */
/* Sprite line checker
   Keeps a reference model of the draw and display lines and compares the
   swept output against it, counting checks and errors */

`timescale 1ns/100ps
`include "spriteLine_defines.svh"

module spriteLineChecker (
	input logic clk_12M,
	input logic nRES,
	input logic lineEnd,
	input logic tileLoad,
	input logic tileReady,
	input logic [`PLANES*`TILE_PIX-1:0] tileData,
	input logic [`LB_ADDR_W-1:0] tileX,
	input logic [`PAL_W-1:0] tilePal,
	input logic [`ENTRY_W-1:0] ob,
	input logic [`LB_ADDR_W-1:0] obX,
	input logic obValid,
	input logic pcof,
	input logic ncoo,
	input logic [8*12-1:0] testName,
	output int errCount,
	output int checkCount,
	output int sweepsDone
);

	import spritePkg::*;

	spritePkg::lbEntry_u drawLine [`LB_DEPTH];	// Line being drawn
	spritePkg::lbEntry_u dispLine [`LB_DEPTH];	// Line being swept out
	logic [8*12-1:0] dispName;
	logic [`LB_ADDR_W-1:0] expX;
	logic nResQ = 1'b0;
	logic sweepArmed = 1'b0;
	spritePkg::lbEntry_u expEntry;
	int outCount = 0;
	int errs = 0;
	int checks = 0;
	int sweeps = 0;
	int errNow;
	int chkNow;

	assign errCount = errs;
	assign checkCount = checks;
	assign sweepsDone = sweeps;

	// Plane p gives colour bit p, MSB of each plane is the leftmost pixel
	function automatic logic [`PIX_W-1:0] pixelColor(
		input logic [`PLANES*`TILE_PIX-1:0] planes,
		input int s
	);
		logic [`PIX_W-1:0] c;
		for (int p = 0; p < `PLANES; p++)
			c[p] = planes[p*`TILE_PIX + `TILE_PIX - 1 - s];
		return c;
	endfunction

	task automatic storeRow(
		input logic [`LB_ADDR_W-1:0] x,
		input logic [`PAL_W-1:0] pal,
		input logic [`PLANES*`TILE_PIX-1:0] planes
	);
		spritePkg::lbEntry_u e;
		logic [`PIX_W-1:0] c;
		for (int s = 0; s < `TILE_PIX; s++) begin
			c = pixelColor(planes, s);
			if (c != '0) begin
				e.f.pal = pal;
				e.f.color = c;
				drawLine[`LB_ADDR_W'(x + s)] = e;	// Wraps past 511
			end
		end
	endtask

	always @(posedge clk_12M) begin
		errNow = 0;
		chkNow = 0;
		if (!nRES || !nResQ) begin
			chkNow++;
			if (!tileReady || obValid) begin
				$display("Error reset: expected tileReady 1 obValid 0, actual tileReady %b obValid %b",
					tileReady, obValid);
				errNow++;
			end
		end
		if (!nRES) begin
			for (int i = 0; i < `LB_DEPTH; i++) begin
				drawLine[i] = '0;
				dispLine[i] = '0;
			end
			expX = '0;
		end else begin
			if (tileLoad && tileReady)
				storeRow(tileX, tilePal, tileData);
			if (obValid) begin
				expEntry = dispLine[obX];
				chkNow++;
				if (obX != expX) begin
					$display("Error %0s: obX expected %0d actual %0d", dispName, expX, obX);
					errNow++;
				end
				if (ob != expEntry.raw) begin
					$display("Error %0s: ob at x=%0d expected %h actual %h",
						dispName, obX, expEntry.raw, ob);
					errNow++;
				end
				if (pcof != (expEntry.f.color == '0)) begin
					$display("Error %0s: pcof at x=%0d expected %b actual %b",
						dispName, obX, expEntry.f.color == '0, pcof);
					errNow++;
				end
				if (ncoo != (expEntry.f.color != 4'hF)) begin
					$display("Error %0s: ncoo at x=%0d expected %b actual %b",
						dispName, obX, expEntry.f.color != 4'hF, ncoo);
					errNow++;
				end
				if (obX == `LB_ADDR_W'(`LB_DEPTH - 1))
					sweeps <= sweeps + 1;
				expX = expX + 1'b1;
				outCount++;
			end
			if (lineEnd) begin
				if (sweepArmed && outCount != `LB_DEPTH) begin
					$display("Error %0s: sweep length expected %0d actual %0d",
						dispName, `LB_DEPTH, outCount);
					errNow++;
				end
				dispLine = drawLine;	// Banks swap roles
				for (int i = 0; i < `LB_DEPTH; i++)
					drawLine[i] = '0;
				dispName = testName;
				expX = '0;
				outCount = 0;
				sweepArmed = 1'b1;
			end
		end
		nResQ <= nRES;
		errs <= errs + errNow;
		checks <= checks + chkNow;
	end

endmodule

/* verif/spriteLineTb.sv */
/* Sprite line path testbench
   Applies a table of tile rows line by line and lets the checker compare
   the swept output against its reference model */

`timescale 1ns/100ps
`include "spriteLine_defines.svh"

module spriteLineTb;

	localparam int NLINES = 5;
	localparam int LINE_CYCLES = 600;
	localparam int READY_TIMEOUT = 20;
	localparam int SWEEP_TIMEOUT = 1200;

	logic clk_12M;
	logic nRES;
	logic lineEnd;
	logic tileLoad;
	logic [`PLANES*`TILE_PIX-1:0] tileData;
	logic [`LB_ADDR_W-1:0] tileX;
	logic [`PAL_W-1:0] tilePal;
	logic tileReady;
	logic [`ENTRY_W-1:0] ob;
	logic [`LB_ADDR_W-1:0] obX;
	logic obValid;
	logic pcof;
	logic ncoo;
	logic [8*12-1:0] testName;
	int errCount;
	int checkCount;
	int sweepsDone;
	int timeouts = 0;
	logic runOk;

	// Stimulus table, one entry per tile row, rows grouped by line
	int rowLine [$];
	logic [`LB_ADDR_W-1:0] rowX [$];
	logic [`PAL_W-1:0] rowPal [$];
	logic [`PLANES*`TILE_PIX-1:0] rowData [$];
	logic [8*12-1:0] lineName [NLINES];

	spriteLineTop spriteLineTop_inst (
		.clk_12M(clk_12M),
		.nRES(nRES),
		.lineEnd(lineEnd),
		.tileLoad(tileLoad),
		.tileData(tileData),
		.tileX(tileX),
		.tilePal(tilePal),
		.tileReady(tileReady),
		.ob(ob),
		.obX(obX),
		.obValid(obValid),
		.pcof(pcof),
		.ncoo(ncoo)
	);

	spriteLineChecker spriteLineChecker_inst (
		.clk_12M(clk_12M),
		.nRES(nRES),
		.lineEnd(lineEnd),
		.tileLoad(tileLoad),
		.tileReady(tileReady),
		.tileData(tileData),
		.tileX(tileX),
		.tilePal(tilePal),
		.ob(ob),
		.obX(obX),
		.obValid(obValid),
		.pcof(pcof),
		.ncoo(ncoo),
		.testName(testName),
		.errCount(errCount),
		.checkCount(checkCount),
		.sweepsDone(sweepsDone)
	);

	initial begin
		clk_12M = 1'b0;
		forever #4 clk_12M = ~clk_12M;	// 8 ns period
	end

	// Planes are given as {plane3, plane2, plane1, plane0}
	task automatic addRow(input int line, input logic [8:0] x, input logic [7:0] pal,
		input logic [31:0] planes);
		rowLine.push_back(line);
		rowX.push_back(x);
		rowPal.push_back(pal);
		rowData.push_back(planes);
	endtask

	task automatic buildTable();
		lineName[0] = "single";
		addRow(0, 9'd20, 8'h3A, {8'hF0, 8'hCC, 8'hAA, 8'hFE});	// Colour 15 first, 0 last
		lineName[1] = "overlap";
		addRow(1, 9'd100, 8'h11, 32'hFFFF_FFFF);
		addRow(1, 9'd104, 8'h22, {8'h00, 8'h00, 8'h00, 8'hA5});	// Holes keep the first tile
		addRow(1, 9'd300, 8'h80, {8'h0F, 8'h33, 8'h55, 8'h00});
		lineName[2] = "cleared";
		lineName[3] = "wrap";
		addRow(3, 9'd508, 8'hC3, {8'h81, 8'h42, 8'h24, 8'h18});
		addRow(3, 9'd250, 8'h5F, 32'hFFFF_0000);
		addRow(3, 9'd254, 8'h07, {8'hFF, 8'h00, 8'hFF, 8'h00});
		addRow(3, 9'd2, 8'h66, {8'h00, 8'hFF, 8'h00, 8'hFF});	// Over the wrapped pixels
		lineName[4] = "empty";
	endtask

	task automatic waitReady(output logic ok);
		ok = 1'b0;
		for (int n = 0; n < READY_TIMEOUT; n++) begin
			@(posedge clk_12M);
			if (tileReady) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("Timeout: tileReady stayed low for %0d cycles", READY_TIMEOUT);
			timeouts++;
		end
	endtask

	task automatic applyRow(input int r, output logic ok);
		waitReady(ok);
		if (ok) begin
			tileLoad <= 1'b1;
			tileX <= rowX[r];
			tilePal <= rowPal[r];
			tileData <= rowData[r];
			@(posedge clk_12M);	// Accepted on this edge
			tileLoad <= 1'b0;
		end
	endtask

	task automatic waitSweeps(output logic ok);
		ok = 1'b0;
		for (int n = 0; n < SWEEP_TIMEOUT; n++) begin
			@(posedge clk_12M);
			if (sweepsDone >= NLINES) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("Timeout: only %0d of %0d line sweeps completed", sweepsDone, NLINES);
			timeouts++;
		end
	endtask

	initial begin
		int r;
		nRES = 1'b0;
		lineEnd = 1'b0;
		tileLoad = 1'b0;
		tileData = '0;
		tileX = '0;
		tilePal = '0;
		runOk = 1'b1;
		buildTable();
		testName = lineName[0];
		repeat (10) @(posedge clk_12M);
		nRES <= 1'b1;
		r = 0;
		for (int ln = 0; ln < NLINES && runOk; ln++) begin
			@(posedge clk_12M);
			testName <= lineName[ln];
			while (runOk && r < rowLine.size() && rowLine[r] == ln) begin
				applyRow(r, runOk);
				r++;
			end
			if (runOk) begin
				repeat (LINE_CYCLES) @(posedge clk_12M);
				lineEnd <= 1'b1;
				@(posedge clk_12M);
				lineEnd <= 1'b0;
			end
		end
		if (runOk)
			waitSweeps(runOk);
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errCount, timeouts);
		if (runOk && errCount == 0 && checkCount > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+src
src/spritePkg.sv
src/tileShifter.sv
src/lineBufferPair.sv
src/pixelOutput.sv
src/spriteLineTop.sv
verif/spriteLineChecker.sv
verif/spriteLineTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the sprite line path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f \
	--top-module spriteLineTb \
	-o simv

./obj_dir/simv | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "Run passed"
	exit 0
else
	echo "Run failed"
	exit 1
fi
